// ==== build.f ====
+incdir+hw
hw/side_ch_pkg.sv
hw/side_ch_regs.sv
hw/side_ch_control.sv
hw/side_ch_m_axis.sv
hw/side_ch.sv
testbench/tb_side_ch.sv

// ==== hw/side_ch.sv ====
// single clock domain; register port has no wait states and reads are combinational
`timescale 1ns/1ps

module side_ch
(
    input  logic                     clk,
    input  logic                     rst_n,

    // from receiver
    input  side_ch_pkg::tsf_t        tsf_runtime_val,
    input  logic                     hdr_strobe,
    input  side_ch_pkg::rx_hdr_t     rx_hdr,
    input  side_ch_pkg::csi_t        csi,
    input  logic                     csi_valid,

    // host registers
    input  logic                     reg_wr,
    input  side_ch_pkg::reg_addr_t   reg_addr,
    input  side_ch_pkg::reg_data_t   reg_wdata,
    output side_ch_pkg::reg_data_t   reg_rdata,

    // axi-stream to host dma
    output logic                     m_axis_tvalid,
    output side_ch_pkg::fifo_word_t  m_axis_tdata,
    output logic                     m_axis_tlast,
    input  logic                     m_axis_tready
);

    side_ch_pkg::side_ch_cfg_t cfg;
    side_ch_pkg::fifo_count_t  fifo_count;
    side_ch_pkg::fifo_word_t   wr_data;
    logic                      trig;
    logic                      wr_en;
    logic                      drop;

    // config, trigger, status read-back
    side_ch_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .cfg        (cfg),
        .trig       (trig),
        .fifo_count (fifo_count),
        .drop       (drop)
    );

    // filter and record writer
    side_ch_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .tsf_runtime_val (tsf_runtime_val),
        .hdr_strobe      (hdr_strobe),
        .rx_hdr          (rx_hdr),
        .csi             (csi),
        .csi_valid       (csi_valid),
        .fifo_count      (fifo_count),
        .wr_en           (wr_en),
        .wr_data         (wr_data),
        .drop            (drop)
    );

    // record fifo and stream out
    side_ch_m_axis u_m_axis (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .trig          (trig),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .fifo_count    (fifo_count),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

endmodule

// ==== hw/side_ch_control.sv ====
// csi_valid is taken from the second cycle after hdr_strobe; headers during a record are ignored
`timescale 1ns/1ps
`include "side_ch_defs.svh"

module side_ch_control
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  side_ch_pkg::side_ch_cfg_t cfg,
    input  side_ch_pkg::tsf_t         tsf_runtime_val,
    input  logic                      hdr_strobe,
    input  side_ch_pkg::rx_hdr_t      rx_hdr,
    input  side_ch_pkg::csi_t         csi,
    input  logic                      csi_valid,
    input  side_ch_pkg::fifo_count_t  fifo_count,
    output logic                      wr_en,
    output side_ch_pkg::fifo_word_t   wr_data,
    output logic                      drop
);

    localparam int CNT_W = $clog2(`SIDE_CH_CSI_WORDS + 1);
    localparam logic [CNT_W-1:0] CSI_LAST = CNT_W'(`SIDE_CH_CSI_WORDS);

    side_ch_pkg::cap_state_e state;
    side_ch_pkg::fifo_word_t hdr_q;
    logic [CNT_W-1:0]        csi_cnt;
    logic                    fc_ok;
    logic                    addr2_ok;
    logic                    pass;
    logic [7:0]              need;
    logic                    fit;
    logic                    accept;

    // filter, disabled comparisons always pass
    assign fc_ok    = !cfg.match_fc_en || (rx_hdr.fc == cfg.fc_target);
    assign addr2_ok = !cfg.match_addr2_en || (rx_hdr.addr2[31:0] == cfg.addr2_target);
    assign pass     = fc_ok && addr2_ok;

    // room for a whole record, checked once at the header
    assign need   = {1'b0, fifo_count} + 8'(`SIDE_CH_REC_WORDS);
    assign fit    = need <= 8'(`SIDE_CH_FIFO_DEPTH);
    assign accept = (state == side_ch_pkg::CAP_IDLE) && hdr_strobe && pass;

    // header word is captured here, not at CAP_HDR
    always_ff @(posedge clk)
    begin
        if (accept && fit)
            hdr_q <= {rx_hdr.rate, rx_hdr.len, rx_hdr.fc, rx_hdr.addr2[23:0]};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= side_ch_pkg::CAP_IDLE;
            csi_cnt <= '0;
            wr_en   <= 1'b0;
            wr_data <= '0;
            drop    <= 1'b0;
        end
        else if (cfg.capture_clear)
        begin
            // abort, partial record stays in fifo
            state   <= side_ch_pkg::CAP_IDLE;
            csi_cnt <= '0;
            wr_en   <= 1'b0;
            drop    <= 1'b0;
        end
        else
        begin
            drop <= accept && !fit;
            case (state)
                side_ch_pkg::CAP_IDLE:
                begin
                    wr_en   <= 1'b0;
                    csi_cnt <= '0;
                    if (accept && fit)
                    begin
                        // word 1 goes out next cycle
                        wr_en   <= 1'b1;
                        wr_data <= tsf_runtime_val;
                        state   <= side_ch_pkg::CAP_TSF;
                    end
                end
                side_ch_pkg::CAP_TSF:
                begin
                    // tsf on the bus now, header next
                    wr_en   <= 1'b1;
                    wr_data <= hdr_q;
                    state   <= side_ch_pkg::CAP_HDR;
                end
                side_ch_pkg::CAP_HDR,
                side_ch_pkg::CAP_CSI:
                begin
                    state <= side_ch_pkg::CAP_CSI;
                    if (csi_cnt == CSI_LAST)
                    begin
                        // last csi word leaves this cycle
                        wr_en <= 1'b0;
                        state <= side_ch_pkg::CAP_IDLE;
                    end
                    else if (csi_valid)
                    begin
                        wr_en   <= 1'b1;
                        wr_data <= {32'd0, csi};
                        csi_cnt <= csi_cnt + 1'b1;
                    end
                    else
                    begin
                        wr_en <= 1'b0;
                    end
                end
                default:
                begin
                    state <= side_ch_pkg::CAP_IDLE;
                    wr_en <= 1'b0;
                end
            endcase
        end
    end

    // every write belongs to an open record
    a_no_wr_idle: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (state != side_ch_pkg::CAP_IDLE));

endmodule

// ==== hw/side_ch_defs.svh ====
// sizes and register map; fifo depth must be a power of two and at most 64 (count width is 7)
`ifndef SIDE_CH_DEFS_SVH
`define SIDE_CH_DEFS_SVH

// record fifo depth in 64-bit words
`define SIDE_CH_FIFO_DEPTH 64

// csi samples taken per record
`define SIDE_CH_CSI_WORDS 8

// timestamp word + header word + csi words
`define SIDE_CH_REC_WORDS (`SIDE_CH_CSI_WORDS + 2)

// register word addresses
`define SIDE_CH_REG_CTRL    0
`define SIDE_CH_REG_CFG     1
`define SIDE_CH_REG_NUM_SYM 2
`define SIDE_CH_REG_TRIG    3
`define SIDE_CH_REG_FC      5
`define SIDE_CH_REG_ADDR2   7
// read-only status
`define SIDE_CH_REG_COUNT   20
`define SIDE_CH_REG_DROP    21

`endif

// ==== hw/side_ch_m_axis.sv ====
// fifo clear is a level and holds the fifo empty; num_dma_symbol of zero never starts a transfer
`timescale 1ns/1ps
`include "side_ch_defs.svh"

module side_ch_m_axis
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  side_ch_pkg::side_ch_cfg_t cfg,
    input  logic                      trig,
    input  logic                      wr_en,
    input  side_ch_pkg::fifo_word_t   wr_data,
    output side_ch_pkg::fifo_count_t  fifo_count,
    output logic                      m_axis_tvalid,
    output side_ch_pkg::fifo_word_t   m_axis_tdata,
    output logic                      m_axis_tlast,
    input  logic                      m_axis_tready
);

    localparam int AW = $clog2(`SIDE_CH_FIFO_DEPTH);

    side_ch_pkg::fifo_word_t  mem [`SIDE_CH_FIFO_DEPTH];
    // pointers carry one wrap bit above the index
    side_ch_pkg::fifo_count_t wr_ptr;
    side_ch_pkg::fifo_count_t rd_ptr;
    side_ch_pkg::fifo_count_t sent;
    side_ch_pkg::fifo_count_t len_q;
    logic                     trig_pend;
    logic                     full;
    logic                     wr_ok;
    logic                     start;
    logic                     beat;

    assign fifo_count = wr_ptr - rd_ptr;
    assign full       = fifo_count == side_ch_pkg::fifo_count_t'(`SIDE_CH_FIFO_DEPTH);
    assign wr_ok      = wr_en && !full && !cfg.fifo_clear;

    // fwft, head word always on tdata
    assign m_axis_tdata = mem[rd_ptr[AW-1:0]];
    assign m_axis_tlast = m_axis_tvalid && (sent == len_q - 1'b1);
    assign beat         = m_axis_tvalid && m_axis_tready;

    // auto mode starts on level, trigger mode needs a trig seen now or earlier
    assign start = !m_axis_tvalid && (cfg.num_dma_symbol != '0)
                   && (fifo_count >= cfg.num_dma_symbol)
                   && (!cfg.start_mode || trig || trig_pend);

    // storage only
    always_ff @(posedge clk)
    begin
        if (wr_ok)
            mem[wr_ptr[AW-1:0]] <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            sent          <= '0;
            len_q         <= '0;
            trig_pend     <= 1'b0;
            m_axis_tvalid <= 1'b0;
        end
        else if (cfg.fifo_clear)
        begin
            // drop stored words and any transfer in flight
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            sent          <= '0;
            trig_pend     <= 1'b0;
            m_axis_tvalid <= 1'b0;
        end
        else
        begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;

            if (start)
            begin
                // length latched so a mid-transfer write can't move tlast
                m_axis_tvalid <= 1'b1;
                len_q         <= cfg.num_dma_symbol;
                sent          <= '0;
            end
            else if (beat)
            begin
                rd_ptr <= rd_ptr + 1'b1;
                if (m_axis_tlast)
                begin
                    m_axis_tvalid <= 1'b0;
                    sent          <= '0;
                end
                else
                begin
                    sent <= sent + 1'b1;
                end
            end

            // trig armed until a transfer consumes it
            if (start)
                trig_pend <= 1'b0;
            else if (trig && cfg.start_mode)
                trig_pend <= 1'b1;
        end
    end

    // capture side must have checked for room
    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !cfg.fifo_clear |-> !full);

    // axi-stream hold rule under back-pressure
    a_tdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready && !cfg.fifo_clear
        |=> m_axis_tvalid && $stable(m_axis_tdata));

endmodule

// ==== hw/side_ch_pkg.sv ====
// shared types; fifo_count_t is sized for a 64-word fifo and must grow with a deeper one
package side_ch_pkg;

    // 802.11 tsf timer
    typedef logic [63:0] tsf_t;
    // i in upper half, q in lower half
    typedef logic [31:0] csi_t;
    typedef logic [63:0] fifo_word_t;
    // occupancy 0..64, also used as fifo pointer with wrap bit
    typedef logic [6:0]  fifo_count_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] fc_t;
    typedef logic [31:0] mac_lo_t;

    // decoded header, valid with hdr_strobe only
    typedef struct packed {
        logic [7:0]  rate;
        logic [15:0] len;
        fc_t         fc;
        logic [47:0] addr2;
    } rx_hdr_t;

    // host configuration
    typedef struct packed {
        logic        fifo_clear;
        logic        capture_clear;
        // 0 automatic, 1 software trigger
        logic        start_mode;
        logic        match_fc_en;
        logic        match_addr2_en;
        fifo_count_t num_dma_symbol;
        fc_t         fc_target;
        mac_lo_t     addr2_target;
    } side_ch_cfg_t;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_TSF,
        CAP_HDR,
        CAP_CSI
    } cap_state_e;

endpackage

// ==== hw/side_ch_regs.sv ====
// clear bits in ctrl are levels and stay active until written back to zero; drop count clears on write
`timescale 1ns/1ps
`include "side_ch_defs.svh"

module side_ch_regs
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_wr,
    input  side_ch_pkg::reg_addr_t   reg_addr,
    input  side_ch_pkg::reg_data_t   reg_wdata,
    output side_ch_pkg::reg_data_t   reg_rdata,
    output side_ch_pkg::side_ch_cfg_t cfg,
    output logic                     trig,
    input  side_ch_pkg::fifo_count_t fifo_count,
    input  logic                     drop
);

    localparam side_ch_pkg::reg_addr_t ADDR_CTRL    = `SIDE_CH_REG_CTRL;
    localparam side_ch_pkg::reg_addr_t ADDR_CFG     = `SIDE_CH_REG_CFG;
    localparam side_ch_pkg::reg_addr_t ADDR_NUM_SYM = `SIDE_CH_REG_NUM_SYM;
    localparam side_ch_pkg::reg_addr_t ADDR_TRIG    = `SIDE_CH_REG_TRIG;
    localparam side_ch_pkg::reg_addr_t ADDR_FC      = `SIDE_CH_REG_FC;
    localparam side_ch_pkg::reg_addr_t ADDR_ADDR2   = `SIDE_CH_REG_ADDR2;
    localparam side_ch_pkg::reg_addr_t ADDR_COUNT   = `SIDE_CH_REG_COUNT;
    localparam side_ch_pkg::reg_addr_t ADDR_DROP    = `SIDE_CH_REG_DROP;

    side_ch_pkg::side_ch_cfg_t cfg_q;
    logic [15:0]               drop_cnt;

    // write side, fields stored straight into the cfg struct
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg_q    <= '0;
            trig     <= 1'b0;
            drop_cnt <= '0;
        end
        else
        begin
            // one-cycle pulse per write to trig address, data ignored
            trig <= reg_wr && (reg_addr == ADDR_TRIG);
            if (reg_wr)
            begin
                case (reg_addr)
                    // bit0 fifo clear, bit2 capture clear
                    ADDR_CTRL:
                    begin
                        cfg_q.fifo_clear    <= reg_wdata[0];
                        cfg_q.capture_clear <= reg_wdata[2];
                    end
                    // bit0 start mode, bits 12/13 filter enables
                    ADDR_CFG:
                    begin
                        cfg_q.start_mode     <= reg_wdata[0];
                        cfg_q.match_fc_en    <= reg_wdata[12];
                        cfg_q.match_addr2_en <= reg_wdata[13];
                    end
                    ADDR_NUM_SYM: cfg_q.num_dma_symbol <= reg_wdata[6:0];
                    ADDR_FC:      cfg_q.fc_target      <= reg_wdata[15:0];
                    ADDR_ADDR2:   cfg_q.addr2_target   <= reg_wdata;
                    default:
                    begin
                    end
                endcase
            end
            // drop counter, write clears, otherwise saturate at all ones
            if (reg_wr && (reg_addr == ADDR_DROP))
                drop_cnt <= '0;
            else if (drop && (drop_cnt != 16'hffff))
                drop_cnt <= drop_cnt + 16'd1;
        end
    end

    assign cfg = cfg_q;

    // combinational read-back
    always_comb
    begin
        case (reg_addr)
            ADDR_CTRL:    reg_rdata = {29'd0, cfg_q.capture_clear, 1'b0, cfg_q.fifo_clear};
            ADDR_CFG:     reg_rdata = {18'd0, cfg_q.match_addr2_en, cfg_q.match_fc_en,
                                       11'd0, cfg_q.start_mode};
            ADDR_NUM_SYM: reg_rdata = {25'd0, cfg_q.num_dma_symbol};
            ADDR_FC:      reg_rdata = {16'd0, cfg_q.fc_target};
            ADDR_ADDR2:   reg_rdata = cfg_q.addr2_target;
            ADDR_COUNT:   reg_rdata = {25'd0, fifo_count};
            ADDR_DROP:    reg_rdata = {16'd0, drop_cnt};
            // trig and unmapped read zero
            default:      reg_rdata = '0;
        endcase
    end

    // trig is a single-cycle pulse, host leaves a cycle between trig writes
    a_trig_single: assert property (@(posedge clk) disable iff (!rst_n)
        trig |=> !trig);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the side channel testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_side_ch -Mdir obj_dir -o tb_side_ch
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/tb_side_ch 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== testbench/tb_side_ch.sv ====
// single clock testbench; expects 10-word records and a 64-word fifo, Verilator needs --timing
`timescale 1ns/1ps
`include "side_ch_defs.svh"

module tb_side_ch;

    localparam int REC = `SIDE_CH_REC_WORDS;
    localparam int DEPTH = `SIDE_CH_FIFO_DEPTH;
    localparam int CSI_N = `SIDE_CH_CSI_WORDS;
    localparam int NUM_PKTS = 33;
    // packets x record length x 4 cycles, plus margin for register traffic
    localparam int WATCHDOG_CYCLES = NUM_PKTS * REC * 4 + 2000;
    localparam int WAIT_LIMIT = 2000;

    logic                      clk;
    logic                      rst_n;
    side_ch_pkg::tsf_t         tsf_runtime_val;
    logic                      hdr_strobe;
    side_ch_pkg::rx_hdr_t      rx_hdr;
    side_ch_pkg::csi_t         csi;
    logic                      csi_valid;
    logic                      reg_wr;
    side_ch_pkg::reg_addr_t    reg_addr;
    side_ch_pkg::reg_data_t    reg_wdata;
    side_ch_pkg::reg_data_t    reg_rdata;
    logic                      m_axis_tvalid;
    side_ch_pkg::fifo_word_t   m_axis_tdata;
    logic                      m_axis_tlast;
    logic                      m_axis_tready;

    // reference model state
    side_ch_pkg::fifo_word_t   exp_q[$];
    int                        errors;
    int                        checks;
    int                        model_drops;
    int                        seen;
    int                        beat_idx;
    int                        num_sym;
    logic                      fc_en;
    logic                      a2_en;
    side_ch_pkg::fc_t          fc_tgt;
    side_ch_pkg::mac_lo_t      a2_tgt;
    logic                      rand_ready;
    logic                      ready_level;
    logic [31:0]               stim_seed;
    logic [31:0]               ready_seed;

    side_ch u_side_ch (
        .clk             (clk),
        .rst_n           (rst_n),
        .tsf_runtime_val (tsf_runtime_val),
        .hdr_strobe      (hdr_strobe),
        .rx_hdr          (rx_hdr),
        .csi             (csi),
        .csi_valid       (csi_valid),
        .reg_wr          (reg_wr),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tready   (m_axis_tready)
    );

    initial
    begin
        clk = 1'b0;
    end

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected record word by position: tsf, header summary, then csi
    function automatic side_ch_pkg::fifo_word_t record_word(input int idx,
            input side_ch_pkg::tsf_t t, input side_ch_pkg::rx_hdr_t h,
            input side_ch_pkg::csi_t c);
        if (idx == 0)
            return t;
        else if (idx == 1)
            return {h.rate, h.len, h.fc, h.addr2[23:0]};
        else
            return {32'd0, c};
    endfunction

    task automatic check_word(input side_ch_pkg::fifo_word_t got,
            input side_ch_pkg::fifo_word_t exp, input logic got_last, input logic exp_last);
        checks++;
        if (got !== exp || got_last !== exp_last)
        begin
            errors++;
            $display("mismatch at %0t: stream word %h last %b, expected %h last %b",
                     $time, got, got_last, exp, exp_last);
        end
    endtask

    task automatic check_reg(input side_ch_pkg::reg_data_t got,
            input side_ch_pkg::reg_data_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s reads %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input side_ch_pkg::reg_addr_t a, input side_ch_pkg::reg_data_t d);
        @(posedge clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    // combinational read, sampled mid-cycle
    task automatic read_reg(input side_ch_pkg::reg_addr_t a, output side_ch_pkg::reg_data_t d);
        @(posedge clk);
        #1;
        reg_addr = a;
        #10;
        d = reg_rdata;
    endtask

    // block until at most keep words are still expected on the stream
    task automatic wait_drain(input int keep);
        int n;
        n = 0;
        while (exp_q.size() > keep && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > keep)
        begin
            errors++;
            $display("error: stream stalled with %0d words still expected", exp_q.size());
        end
    endtask

    // one header, then 8 csi samples starting two cycles after the strobe
    task automatic send_packet(input side_ch_pkg::fc_t fc, input side_ch_pkg::mac_lo_t a2lo);
        side_ch_pkg::rx_hdr_t hdr;
        side_ch_pkg::tsf_t    t;
        side_ch_pkg::csi_t    samples[CSI_N];
        logic                 pass;
        int                   i;
        stim_seed = lcg_next(stim_seed);
        t[63:32] = stim_seed;
        stim_seed = lcg_next(stim_seed);
        t[31:0] = stim_seed;
        stim_seed = lcg_next(stim_seed);
        hdr.rate  = stim_seed[31:24];
        hdr.len   = stim_seed[23:8];
        hdr.fc    = fc;
        stim_seed = lcg_next(stim_seed);
        hdr.addr2 = {stim_seed[31:16], a2lo};
        for (i = 0; i < CSI_N; i++)
        begin
            stim_seed = lcg_next(stim_seed);
            samples[i] = stim_seed;
        end
        // filter rule, then room for the whole record
        pass = (!fc_en || fc == fc_tgt) && (!a2_en || a2lo == a2_tgt);
        if (pass)
        begin
            if (exp_q.size() + REC <= DEPTH)
            begin
                for (i = 0; i < REC; i++)
                    exp_q.push_back(record_word(i, t, hdr, samples[(i < 2) ? 0 : i - 2]));
            end
            else
                model_drops++;
        end
        @(posedge clk);
        #1;
        hdr_strobe      = 1'b1;
        rx_hdr          = hdr;
        tsf_runtime_val = t;
        @(posedge clk);
        #1;
        hdr_strobe = 1'b0;
        rx_hdr     = '0;
        // timer keeps running, only the strobe value counts
        tsf_runtime_val = t + 64'd1;
        for (i = 0; i < CSI_N; i++)
        begin
            @(posedge clk);
            #1;
            csi_valid = 1'b1;
            csi       = samples[i];
        end
        @(posedge clk);
        #1;
        csi_valid = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // tready, random or held at a level
    always @(posedge clk)
    begin
        #1;
        if (rand_ready)
        begin
            ready_seed = lcg_next(ready_seed);
            m_axis_tready = ready_seed[20];
        end
        else
            m_axis_tready = ready_level;
    end

    // a beat seen at the negedge completes at the next rising edge
    always @(negedge clk)
    begin
        if (rst_n && m_axis_tvalid && m_axis_tready)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("error: stream word %h arrived with nothing expected", m_axis_tdata);
            end
            else
            begin
                check_word(m_axis_tdata, exp_q.pop_front(), m_axis_tlast,
                           beat_idx == num_sym - 1);
                beat_idx = (beat_idx == num_sym - 1) ? 0 : beat_idx + 1;
            end
            seen++;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        side_ch_pkg::reg_data_t rd;
        int                     s0;
        int                     i;
        logic                   fc_ok;
        logic                   a2_ok;
        rst_n           = 1'b0;
        tsf_runtime_val = '0;
        hdr_strobe      = 1'b0;
        rx_hdr          = '0;
        csi             = '0;
        csi_valid       = 1'b0;
        reg_wr          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        m_axis_tready   = 1'b0;
        errors = 0;
        checks = 0;
        model_drops = 0;
        seen = 0;
        beat_idx = 0;
        num_sym = REC;
        fc_en = 1'b0;
        a2_en = 1'b0;
        fc_tgt = '0;
        a2_tgt = '0;
        rand_ready = 1'b0;
        ready_level = 1'b1;
        stim_seed = 32'd83539;
        ready_seed = lcg_next(32'd83539);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        read_reg(`SIDE_CH_REG_DROP, rd);
        check_reg(rd, 0, "drop count after reset");

        // one record per transfer, no filter, automatic start
        write_reg(`SIDE_CH_REG_NUM_SYM, REC);
        for (i = 0; i < 4; i++)
        begin
            stim_seed = lcg_next(stim_seed);
            send_packet(stim_seed[31:16], stim_seed);
        end
        wait_drain(0);

        // fc and addr2 filter, fifo idle before each header
        fc_tgt = 16'h0208;
        a2_tgt = 32'h1234_5678;
        write_reg(`SIDE_CH_REG_FC, fc_tgt);
        write_reg(`SIDE_CH_REG_ADDR2, a2_tgt);
        write_reg(`SIDE_CH_REG_CFG, 32'h0000_3000);
        fc_en = 1'b1;
        a2_en = 1'b1;
        for (i = 0; i < 6; i++)
        begin
            fc_ok = (i != 1) && (i != 4);
            a2_ok = (i != 2) && (i != 4);
            wait_drain(0);
            send_packet(fc_ok ? fc_tgt : fc_tgt ^ 16'h0040,
                        a2_ok ? a2_tgt : a2_tgt ^ 32'h0000_0100);
            if (!(fc_ok && a2_ok))
            begin
                read_reg(`SIDE_CH_REG_COUNT, rd);
                check_reg(rd, 0, "fifo count after filtered header");
            end
        end
        wait_drain(0);

        // random back-pressure
        write_reg(`SIDE_CH_REG_CFG, 0);
        fc_en = 1'b0;
        a2_en = 1'b0;
        rand_ready = 1'b1;
        for (i = 0; i < 12; i++)
        begin
            wait_drain(DEPTH - REC);
            stim_seed = lcg_next(stim_seed);
            send_packet(stim_seed[31:16], stim_seed);
        end
        wait_drain(0);
        rand_ready = 1'b0;

        // tready low, fifo overflows and records drop
        ready_level = 1'b0;
        for (i = 0; i < 8; i++)
        begin
            stim_seed = lcg_next(stim_seed);
            send_packet(stim_seed[31:16], stim_seed);
        end
        read_reg(`SIDE_CH_REG_DROP, rd);
        check_reg(rd, model_drops, "drop count");
        read_reg(`SIDE_CH_REG_COUNT, rd);
        check_reg(rd, exp_q.size(), "fifo count while stalled");
        ready_level = 1'b1;
        wait_drain(0);

        // trigger mode, two records stored, one transfer released
        write_reg(`SIDE_CH_REG_CFG, 1);
        s0 = seen;
        for (i = 0; i < 2; i++)
        begin
            stim_seed = lcg_next(stim_seed);
            send_packet(stim_seed[31:16], stim_seed);
        end
        repeat (20) @(posedge clk);
        if (seen != s0)
        begin
            errors++;
            $display("error: %0d words left before the trigger write", seen - s0);
        end
        read_reg(`SIDE_CH_REG_COUNT, rd);
        check_reg(rd, exp_q.size(), "fifo count before trigger");
        write_reg(`SIDE_CH_REG_TRIG, 1);
        wait_drain(exp_q.size() - num_sym);
        repeat (20) @(posedge clk);
        if (seen != s0 + num_sym)
        begin
            errors++;
            $display("error: trigger released %0d words, expected %0d", seen - s0, num_sym);
        end
        read_reg(`SIDE_CH_REG_COUNT, rd);
        check_reg(rd, exp_q.size(), "fifo count after trigger");

        // fifo clear drops the pending record
        write_reg(`SIDE_CH_REG_CTRL, 1);
        read_reg(`SIDE_CH_REG_COUNT, rd);
        check_reg(rd, 0, "fifo count during clear");
        write_reg(`SIDE_CH_REG_CTRL, 0);
        exp_q.delete();
        beat_idx = 0;
        write_reg(`SIDE_CH_REG_CFG, 0);
        stim_seed = lcg_next(stim_seed);
        send_packet(stim_seed[31:16], stim_seed);
        wait_drain(0);
        read_reg(`SIDE_CH_REG_COUNT, rd);
        check_reg(rd, 0, "fifo count at end");

        repeat (5) @(posedge clk);
        $display("checks %0d, errors %0d, drops %0d", checks, errors, model_drops);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
